// ==== hazard_pkg.sv ====
package hazard_pkg;

    // widths with a meaning of their own
    localparam int REG_IDX_W = 5;                       // 32 registers in the register file
    localparam int ISA_W     = 32;                      // instruction word and pc width

    typedef logic [REG_IDX_W-1:0] reg_idx_t;            // register file index
    typedef logic [ISA_W-1:0]     pc_t;                 // program counter value
    typedef logic [2:0]           gap_cnt_t;            // drain counter, good for STAGE_CNT <= 7

    // per-stage control seen by every stage register
    typedef enum logic [1:0] {
        HAZD_NORMAL = 2'b00,                            // advance as usual
        HAZD_RETRY  = 2'b01,                            // hold the stage and repeat it
        HAZD_NO_OP  = 2'b10                             // load a bubble
    } hazd_ctl_t;

    // what the cpu is busy with, shown on the display
    typedef enum logic [2:0] {
        ISSUE_NONE        = 3'd0,
        ISSUE_DATA        = 3'd1,                       // data hazard stall
        ISSUE_PAUSE       = 3'd2,                       // user pause
        ISSUE_FALLTHROUGH = 3'd3,                       // pc ran past the last instruction
        ISSUE_UART        = 3'd4                        // uart rewrite in progress
    } issue_t;

    typedef enum logic [1:0] {
        IDLE    = 2'b00,                                // one cycle for fetch to settle
        EXECUTE = 2'b01,
        HAZARD  = 2'b10
    } cpu_state_t;

    typedef struct packed {
        reg_idx_t reg_1_idx;                            // first source register
        reg_idx_t reg_2_idx;                            // second source register
        reg_idx_t dest_idx;                             // destination, or source of a store
        logic     branch;                               // branch instruction in decode
        logic     store;                                // store instruction in decode
    } id_ops_t;

    typedef struct packed {
        logic     reg_write_enable;                     // stage writes the register file
        logic     no_op;                                // stage holds a bubble
        reg_idx_t dest_idx;                             // register written back
    } stage_wb_t;

    typedef struct packed {
        hazd_ctl_t if_ctl;
        hazd_ctl_t id_ctl;
        hazd_ctl_t ex_ctl;
        hazd_ctl_t mem_ctl;
        hazd_ctl_t wb_ctl;
    } stage_ctl_t;

endpackage

// ==== hazard_detect.sv ====
`timescale 1ns/1ps

module hazard_detect
    import hazard_pkg::*;
#(
    parameter pc_t PC_MAX = 16383                       // last instruction address
) (
    input  id_ops_t   id_ops,                           // decode stage operands
    input  stage_wb_t ex_stage,                         // write-back info of ex
    input  stage_wb_t mem_stage,                        // write-back info of mem
    input  logic      ex_mem_read_enable,               // ex holds a load
    input  logic      if_no_op,                         // fetch holds a bubble
    input  pc_t       pc,
    output logic      data_hazard,
    output logic      fallthrough
);

    logic reg_1_valid;
    logic reg_2_valid;
    logic ex_active;
    logic mem_active;
    logic ex_src_match;
    logic mem_src_match;
    logic store_match;
    logic ex_conflict;
    logic mem_conflict;

    // register zero is hard wired, never a dependency
    assign reg_1_valid = (id_ops.reg_1_idx != '0);
    assign reg_2_valid = (id_ops.reg_2_idx != '0);

    // only a real writing instruction can conflict
    assign ex_active  = ex_stage.reg_write_enable & ~ex_stage.no_op;
    assign mem_active = mem_stage.reg_write_enable & ~mem_stage.no_op;

    assign ex_src_match  = (reg_1_valid & (id_ops.reg_1_idx == ex_stage.dest_idx)) |
                           (reg_2_valid & (id_ops.reg_2_idx == ex_stage.dest_idx));
    assign mem_src_match = (reg_1_valid & (id_ops.reg_1_idx == mem_stage.dest_idx)) |
                           (reg_2_valid & (id_ops.reg_2_idx == mem_stage.dest_idx));

    // store data comes from the result still sitting in ex
    assign store_match = id_ops.store & (id_ops.dest_idx == ex_stage.dest_idx);

    assign ex_conflict  = ex_active & (ex_src_match | store_match);
    assign mem_conflict = mem_active & mem_src_match;

    // branch resolves in decode, so it waits on both later stages
    // a load in ex has no data until mem, so the next user must wait
    assign data_hazard = (id_ops.branch & (ex_conflict | mem_conflict)) |
                         (ex_mem_read_enable & ex_conflict);

    // a real instruction fetched at the last address means the program ran off the end
    assign fallthrough = (pc == PC_MAX) & ~if_no_op;

endmodule

// ==== hazard_fsm.sv ====
`timescale 1ns/1ps

module hazard_fsm
    import hazard_pkg::*;
#(
    parameter int STAGE_CNT = 5                         // drain cycles before the hand-off
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       data_hazard,                     // from hazard_detect
    input  logic       fallthrough,                     // from hazard_detect
    input  logic       cpu_pause,                       // user pressed pause
    input  logic       uart_write_enable,               // uart loader is writing
    input  logic       uart_complete,                   // uart loader finished
    output stage_ctl_t stage_ctl,                       // control for every stage register
    output issue_t     issue_type,                      // for the display unit
    output logic       uart_disable,                    // memories stay with the cpu while high
    output logic       ignore_pause,                    // input unit drops resume during rewrite
    output logic       pc_reset                         // one cycle pulse, pc back to 0
);

    cpu_state_t cpu_state;
    cpu_state_t state_nxt;
    gap_cnt_t   gap_cnt;
    gap_cnt_t   gap_nxt;
    stage_ctl_t ctl_nxt;
    issue_t     issue_nxt;
    logic       uart_dis_nxt;
    logic       ign_pause_nxt;
    logic       pc_reset_nxt;
    logic       drain_req;

    assign drain_req = cpu_pause | fallthrough;         // both need an empty pipeline

    always_comb begin
        state_nxt     = cpu_state;                      // hold by default
        gap_nxt       = gap_cnt;
        ctl_nxt       = stage_ctl;
        issue_nxt     = issue_type;
        uart_dis_nxt  = uart_disable;
        ign_pause_nxt = ignore_pause;
        pc_reset_nxt  = pc_reset;

        case (cpu_state)
            EXECUTE: begin
                if (data_hazard) begin                  // pause can wait until the stall clears
                    issue_nxt      = ISSUE_DATA;
                    state_nxt      = HAZARD;
                    ctl_nxt.if_ctl = HAZD_RETRY;        // refetch the same instruction
                    ctl_nxt.id_ctl = HAZD_RETRY;        // decode again next cycle
                    ctl_nxt.ex_ctl = HAZD_NO_OP;        // bubble into ex
                end else if (drain_req) begin
                    ctl_nxt.if_ctl = HAZD_NO_OP;        // feed bubbles, pc may still move
                    if (gap_cnt == gap_cnt_t'(STAGE_CNT)) begin
                        gap_nxt      = '0;
                        issue_nxt    = cpu_pause ? ISSUE_PAUSE : ISSUE_FALLTHROUGH;
                        state_nxt    = HAZARD;
                        uart_dis_nxt = 1'b0;            // pipeline empty, memories go to uart
                    end else begin
                        gap_nxt = gap_cnt + 1'b1;
                    end
                end else begin
                    gap_nxt        = '0;                // request dropped mid drain
                    ctl_nxt.if_ctl = HAZD_NORMAL;
                end
            end

            HAZARD: begin
                case (issue_type)
                    ISSUE_DATA: begin
                        if (!data_hazard) begin
                            issue_nxt      = ISSUE_NONE;
                            state_nxt      = EXECUTE;
                            ctl_nxt.if_ctl = HAZD_NORMAL;
                            ctl_nxt.id_ctl = HAZD_NORMAL;
                            ctl_nxt.ex_ctl = HAZD_NORMAL;
                            if (drain_req) begin
                                ctl_nxt.if_ctl = HAZD_NO_OP;    // drain starts right away
                                gap_nxt        = gap_cnt + 1'b1;
                            end else begin
                                gap_nxt = '0;
                            end
                        end
                    end

                    ISSUE_FALLTHROUGH: begin
                        if (!fallthrough) begin         // last jump resolved, pc moved away
                            issue_nxt      = ISSUE_NONE;
                            state_nxt      = EXECUTE;
                            uart_dis_nxt   = 1'b1;
                            ctl_nxt.if_ctl = HAZD_NORMAL;
                        end else if (uart_write_enable) begin
                            issue_nxt     = ISSUE_UART;
                            ign_pause_nxt = 1'b1;
                        end else if (cpu_pause) begin
                            issue_nxt    = ISSUE_PAUSE;
                            pc_reset_nxt = 1'b1;        // restart the program from 0
                        end
                    end

                    ISSUE_PAUSE: begin
                        pc_reset_nxt = 1'b0;            // ends the pulse from uart or fallthrough
                        if (uart_write_enable) begin
                            issue_nxt     = ISSUE_UART;
                            ign_pause_nxt = 1'b1;
                        end else if (!cpu_pause) begin  // user resumed
                            issue_nxt      = ISSUE_NONE;
                            state_nxt      = EXECUTE;
                            uart_dis_nxt   = 1'b1;
                            ctl_nxt.if_ctl = HAZD_NORMAL;
                        end
                    end

                    ISSUE_UART: begin
                        if (uart_complete) begin
                            issue_nxt     = ISSUE_PAUSE;
                            ign_pause_nxt = 1'b0;
                            pc_reset_nxt  = 1'b1;       // new program starts at 0
                        end
                    end

                    default: begin
                        issue_nxt = issue_type;         // ISSUE_NONE never sits in HAZARD
                    end
                endcase
            end

            default: begin
                state_nxt = EXECUTE;                    // idle gives fetch one cycle
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cpu_state          <= IDLE;
            gap_cnt            <= '0;
            stage_ctl.if_ctl   <= HAZD_NORMAL;
            stage_ctl.id_ctl   <= HAZD_NORMAL;
            stage_ctl.ex_ctl   <= HAZD_NORMAL;
            stage_ctl.mem_ctl  <= HAZD_NORMAL;
            stage_ctl.wb_ctl   <= HAZD_NORMAL;
            issue_type         <= ISSUE_NONE;
            uart_disable       <= 1'b1;                 // cpu owns the memories out of reset
            ignore_pause       <= 1'b0;
            pc_reset           <= 1'b0;
        end else begin
            cpu_state    <= state_nxt;
            gap_cnt      <= gap_nxt;
            stage_ctl    <= ctl_nxt;
            issue_type   <= issue_nxt;
            uart_disable <= uart_dis_nxt;
            ignore_pause <= ign_pause_nxt;
            pc_reset     <= pc_reset_nxt;
        end
    end

endmodule

// ==== hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit
    import hazard_pkg::*;
#(
    parameter pc_t PC_MAX    = 16383,                   // last instruction address
    parameter int  STAGE_CNT = 5                        // drain cycles, at most 7
) (
    input  logic       clk,
    input  logic       rst_n,

    input  id_ops_t    id_ops,                          // from decode
    input  stage_wb_t  ex_stage,                        // from the id/ex register
    input  stage_wb_t  mem_stage,                       // from the ex/mem register
    input  logic       ex_mem_read_enable,              // load in ex
    input  logic       if_no_op,                        // fetch holds a bubble
    input  pc_t        pc,                              // from instruction memory

    input  logic       cpu_pause,                       // from the input unit
    input  logic       uart_write_enable,               // from the uart loader
    input  logic       uart_complete,                   // from the uart loader

    output stage_ctl_t stage_ctl,                       // to every stage register
    output issue_t     issue_type,                      // to the display unit
    output logic       uart_disable,                    // to uart loader and both memories
    output logic       ignore_pause,                    // to the input unit
    output logic       pc_reset                         // to instruction memory
);

    logic data_hazard;
    logic fallthrough;

    hazard_detect #(
        .PC_MAX (PC_MAX)
    ) u_detect (
        .id_ops             (id_ops),
        .ex_stage           (ex_stage),
        .mem_stage          (mem_stage),
        .ex_mem_read_enable (ex_mem_read_enable),
        .if_no_op           (if_no_op),
        .pc                 (pc),
        .data_hazard        (data_hazard),
        .fallthrough        (fallthrough)
    );

    hazard_fsm #(
        .STAGE_CNT (STAGE_CNT)
    ) u_fsm (
        .clk               (clk),
        .rst_n             (rst_n),
        .data_hazard       (data_hazard),
        .fallthrough       (fallthrough),
        .cpu_pause         (cpu_pause),
        .uart_write_enable (uart_write_enable),
        .uart_complete     (uart_complete),
        .stage_ctl         (stage_ctl),
        .issue_type        (issue_type),
        .uart_disable      (uart_disable),
        .ignore_pause      (ignore_pause),
        .pc_reset          (pc_reset)
    );

endmodule

// ==== hazard_unit_tb.sv ====
`timescale 1ns/1ps

module hazard_unit_tb
    import hazard_pkg::*;
();

    localparam int  STAGE_CNT     = 5;
    localparam pc_t PC_MAX        = 16383;
    localparam int  HEADER_LINES  = 2;                  // column legend at the top of the data file
    localparam int  LINE_LIMIT    = 500;                // data lines read at most
    localparam int  READY_TIMEOUT = 8;                  // cycles allowed to get back to plain execute
    localparam int  SWEEP_CNT     = 200;                // random operand sets

    logic       clk;
    logic       rst_n;
    id_ops_t    id_ops;
    stage_wb_t  ex_stage;
    stage_wb_t  mem_stage;
    logic       ex_mem_read_enable;
    logic       if_no_op;
    pc_t        pc;
    logic       cpu_pause;
    logic       uart_write_enable;
    logic       uart_complete;
    stage_ctl_t stage_ctl;
    issue_t     issue_type;
    logic       uart_disable;
    logic       ignore_pause;
    logic       pc_reset;

    int         err_cnt;                                // failed checks
    int         check_cnt;                              // checked steps
    integer     seed;                                   // $random state

    hazard_unit #(
        .PC_MAX    (PC_MAX),
        .STAGE_CNT (STAGE_CNT)
    ) dut0 (
        .clk                (clk),
        .rst_n              (rst_n),
        .id_ops             (id_ops),
        .ex_stage           (ex_stage),
        .mem_stage          (mem_stage),
        .ex_mem_read_enable (ex_mem_read_enable),
        .if_no_op           (if_no_op),
        .pc                 (pc),
        .cpu_pause          (cpu_pause),
        .uart_write_enable  (uart_write_enable),
        .uart_complete      (uart_complete),
        .stage_ctl          (stage_ctl),
        .issue_type         (issue_type),
        .uart_disable       (uart_disable),
        .ignore_pause       (ignore_pause),
        .pc_reset           (pc_reset)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                          // 4 ns period
    end

    task automatic clear_inputs();
        id_ops             = '0;
        ex_stage           = '0;
        mem_stage          = '0;
        ex_mem_read_enable = 1'b0;
        if_no_op           = 1'b0;
        pc                 = '0;                        // far from the last address
        cpu_pause          = 1'b0;
        uart_write_enable  = 1'b0;
        uart_complete      = 1'b0;
    endtask

    task automatic step_clock();
        @(posedge clk);                                 // dut reacts here
        @(negedge clk);                                 // outputs stable, next drive point
    endtask

    // reference model of the detection rule, written per source register
    function automatic logic predict_hazard(input id_ops_t ops, input stage_wb_t ex,
                                            input stage_wb_t mem, input logic load_in_ex);
        reg_idx_t srcs [0:1];
        logic     ex_hit;
        logic     mem_hit;
        int       k;

        srcs[0] = ops.reg_1_idx;
        srcs[1] = ops.reg_2_idx;
        ex_hit  = 1'b0;
        mem_hit = 1'b0;
        for (k = 0; k < 2; k++) begin
            if (srcs[k] != 5'd0) begin                  // r0 never creates a dependency
                if (srcs[k] == ex.dest_idx)
                    ex_hit = 1'b1;
                if (srcs[k] == mem.dest_idx)
                    mem_hit = 1'b1;
            end
        end
        if (ops.store && ops.dest_idx == ex.dest_idx)
            ex_hit = 1'b1;                              // store data still in ex
        if (!ex.reg_write_enable || ex.no_op)
            ex_hit = 1'b0;
        if (!mem.reg_write_enable || mem.no_op)
            mem_hit = 1'b0;
        if (ops.branch)
            return ex_hit || mem_hit;
        return load_in_ex && ex_hit;
    endfunction

    task automatic check_outputs(input int line_no, input logic [9:0] ctl_exp,
                                 input logic [2:0] issue_exp, input logic udis_exp,
                                 input logic ign_exp, input logic pcr_exp);
        check_cnt++;
        if (stage_ctl !== ctl_exp) begin
            $display("mismatch step %0d stage_ctl got %h expected %h", line_no, stage_ctl, ctl_exp);
            err_cnt++;
        end
        if (issue_type !== issue_exp) begin
            $display("mismatch step %0d issue_type got %h expected %h",
                     line_no, issue_type, issue_exp);
            err_cnt++;
        end
        if (uart_disable !== udis_exp) begin
            $display("mismatch step %0d uart_disable got %h expected %h",
                     line_no, uart_disable, udis_exp);
            err_cnt++;
        end
        if (ignore_pause !== ign_exp) begin
            $display("mismatch step %0d ignore_pause got %h expected %h",
                     line_no, ignore_pause, ign_exp);
            err_cnt++;
        end
        if (pc_reset !== pcr_exp) begin
            $display("mismatch step %0d pc_reset got %h expected %h", line_no, pc_reset, pcr_exp);
            err_cnt++;
        end
    endtask

    task automatic skip_line(input int fd);
        int c;
        int n;

        c = 0;
        n = 0;
        while (c != 10 && c != -1 && n < 1024) begin   // up to newline or end of file
            c = $fgetc(fd);
            n++;
        end
    endtask

    task automatic wait_ready(output logic ready);
        int waited;

        waited = 0;
        while ((issue_type !== ISSUE_NONE || stage_ctl !== '0) && waited < READY_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        ready = (issue_type === ISSUE_NONE) && (stage_ctl === '0);
    endtask

    task automatic run_file();
        int          fd;
        int          got;
        int          steps;
        int          reads;
        int          h;
        logic        done;
        logic [16:0] ops_v;
        logic [6:0]  ex_v;
        logic [6:0]  mem_v;
        logic        mre_v;
        logic        ifnop_v;
        logic [31:0] pc_v;
        logic        pause_v;
        logic        uwe_v;
        logic        ucomp_v;
        logic [9:0]  ctl_exp;
        logic [2:0]  issue_exp;
        logic        udis_exp;
        logic        ign_exp;
        logic        pcr_exp;

        fd = $fopen("hazard_tests.txt", "r");
        if (fd == 0) begin
            $display("error: could not open hazard_tests.txt");
            err_cnt++;
            return;
        end
        for (h = 0; h < HEADER_LINES; h++)
            skip_line(fd);
        steps = 0;
        reads = 0;
        done  = 1'b0;
        while (!done && reads < LINE_LIMIT) begin
            reads++;
            got = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          ops_v, ex_v, mem_v, mre_v, ifnop_v, pc_v, pause_v, uwe_v, ucomp_v,
                          ctl_exp, issue_exp, udis_exp, ign_exp, pcr_exp);
            if (got == 14) begin
                steps++;
                id_ops             = ops_v;             // drive on the falling edge
                ex_stage           = ex_v;
                mem_stage          = mem_v;
                ex_mem_read_enable = mre_v;
                if_no_op           = ifnop_v;
                pc                 = pc_v;
                cpu_pause          = pause_v;
                uart_write_enable  = uwe_v;
                uart_complete      = ucomp_v;
                step_clock();
                check_outputs(steps, ctl_exp, issue_exp, udis_exp, ign_exp, pcr_exp);
            end else if (got <= 0 && $feof(fd)) begin
                done = 1'b1;                            // clean end of data
            end else begin
                $display("error: data line %0d of hazard_tests.txt is malformed", steps + 1);
                err_cnt++;
                done = 1'b1;
            end
        end
        if (!done) begin
            $display("error: hazard_tests.txt did not end within %0d lines", LINE_LIMIT);
            err_cnt++;
        end
        if (steps == 0) begin
            $display("error: hazard_tests.txt held no test steps");
            err_cnt++;
        end
        $fclose(fd);
        clear_inputs();
    endtask

    task automatic sweep_detection();
        logic [31:0] rnd;
        logic        hazard_exp;
        logic        ready;
        hazd_ctl_t   ex_exp;
        issue_t      issue_exp;
        int          n;
        int          hits;

        wait_ready(ready);
        if (!ready) begin
            $display("error: dut never settled in plain execute before the random sweep");
            err_cnt++;
            return;
        end
        hits = 0;
        for (n = 0; n < SWEEP_CNT; n++) begin
            rnd = $random(seed);
            clear_inputs();
            id_ops.reg_1_idx       = {3'b000, rnd[1:0]};   // small indices so matches are common
            id_ops.reg_2_idx       = {3'b000, rnd[3:2]};
            id_ops.dest_idx        = {3'b000, rnd[5:4]};
            id_ops.branch          = rnd[6];
            id_ops.store           = rnd[7];
            ex_stage.reg_write_enable  = rnd[8];
            ex_stage.no_op             = rnd[9] & rnd[10];  // bubble one time in four
            ex_stage.dest_idx          = {3'b000, rnd[12:11]};
            mem_stage.reg_write_enable = rnd[13];
            mem_stage.no_op            = rnd[14] & rnd[15];
            mem_stage.dest_idx         = {3'b000, rnd[17:16]};
            ex_mem_read_enable     = rnd[18];
            if_no_op               = rnd[19];
            hazard_exp = predict_hazard(id_ops, ex_stage, mem_stage, ex_mem_read_enable);
            ex_exp     = hazard_exp ? HAZD_NO_OP : HAZD_NORMAL;
            issue_exp  = hazard_exp ? ISSUE_DATA : ISSUE_NONE;
            if (hazard_exp)
                hits++;
            step_clock();
            check_cnt++;
            if (stage_ctl.ex_ctl !== ex_exp) begin
                $display("mismatch sweep %0d ex_ctl got %h expected %h (id_ops %h ex %h mem %h)",
                         n, stage_ctl.ex_ctl, ex_exp, id_ops, ex_stage, mem_stage);
                err_cnt++;
            end
            if (issue_type !== issue_exp) begin
                $display("mismatch sweep %0d issue_type got %h expected %h", n, issue_type, issue_exp);
                err_cnt++;
            end
            clear_inputs();                             // conflict gone for one edge
            step_clock();
            wait_ready(ready);
            if (!ready) begin
                $display("error: dut stayed stalled after the conflict of sweep set %0d cleared", n);
                err_cnt++;
                return;
            end
        end
        if (hits == 0 || hits == SWEEP_CNT) begin
            $display("error: random sweep did not produce both hazard and no-hazard sets");
            err_cnt++;
        end
    endtask

    initial begin
        err_cnt   = 0;
        check_cnt = 0;
        seed      = 37;
        rst_n     = 1'b0;
        clear_inputs();
        repeat (2) @(posedge clk);                      // reset held for two cycles
        @(negedge clk);
        rst_n = 1'b1;
        run_file();
        sweep_detection();
        $display("%0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== hazard_tests.txt ====
# inputs in hex: id_ops ex_stage mem_stage ex_mem_rd if_no_op pc cpu_pause uart_we uart_done
# then expected after one rising edge: stage_ctl issue_type uart_disable ignore_pause pc_reset
00000 00 00 0 0 0000 0 0 0  000 0 1 0 0
03000 43 00 1 0 0000 0 0 0  160 1 1 0 0
03000 43 00 1 0 0000 0 0 0  160 1 1 0 0
00000 00 00 0 0 0000 0 0 0  000 0 1 0 0
00280 40 00 1 0 0000 0 0 0  000 0 1 0 0
03000 63 00 1 0 0000 0 0 0  000 0 1 0 0
03000 03 00 1 0 0000 0 0 0  000 0 1 0 0
00382 00 47 0 0 0000 0 0 0  160 1 1 0 0
00000 00 00 0 0 0000 0 0 0  000 0 1 0 0
00025 49 00 1 0 0000 0 0 0  160 1 1 0 0
00000 00 00 0 0 0000 0 0 0  000 0 1 0 0
04000 00 44 1 0 0000 0 0 0  000 0 1 0 0
00000 00 00 0 0 0000 1 0 0  200 0 1 0 0
00000 00 00 0 0 0000 1 0 0  200 0 1 0 0
00000 00 00 0 0 0000 1 0 0  200 0 1 0 0
00000 00 00 0 0 0000 1 0 0  200 0 1 0 0
00000 00 00 0 0 0000 1 0 0  200 0 1 0 0
00000 00 00 0 0 0000 1 0 0  200 2 0 0 0
00000 00 00 0 0 0000 1 0 0  200 2 0 0 0
00000 00 00 0 0 0000 0 0 0  000 0 1 0 0
00000 00 00 0 0 0000 1 0 0  200 0 1 0 0
00000 00 00 0 0 0000 1 0 0  200 0 1 0 0
00000 00 00 0 0 0000 1 0 0  200 0 1 0 0
00000 00 00 0 0 0000 1 0 0  200 0 1 0 0
00000 00 00 0 0 0000 1 0 0  200 0 1 0 0
00000 00 00 0 0 0000 1 0 0  200 2 0 0 0
00000 00 00 0 0 0000 1 1 0  200 4 0 1 0
00000 00 00 0 0 0000 1 1 0  200 4 0 1 0
00000 00 00 0 0 0000 1 0 1  200 2 0 0 1
00000 00 00 0 0 0000 1 0 0  200 2 0 0 0
00000 00 00 0 0 0000 0 0 0  000 0 1 0 0
00000 00 00 0 0 3fff 0 0 0  200 0 1 0 0
00000 00 00 0 0 3fff 0 0 0  200 0 1 0 0
00000 00 00 0 0 3fff 0 0 0  200 0 1 0 0
00000 00 00 0 0 3fff 0 0 0  200 0 1 0 0
00000 00 00 0 0 3fff 0 0 0  200 0 1 0 0
00000 00 00 0 0 3fff 0 0 0  200 3 0 0 0
00000 00 00 0 0 3fff 1 0 0  200 2 0 0 1
00000 00 00 0 0 3fff 1 0 0  200 2 0 0 0
00000 00 00 0 0 0000 0 0 0  000 0 1 0 0
00000 00 00 0 0 3fff 0 0 0  200 0 1 0 0
00000 00 00 0 0 3fff 0 0 0  200 0 1 0 0
00000 00 00 0 0 3fff 0 0 0  200 0 1 0 0
00000 00 00 0 0 3fff 0 0 0  200 0 1 0 0
00000 00 00 0 0 3fff 0 0 0  200 0 1 0 0
00000 00 00 0 0 3fff 0 0 0  200 3 0 0 0
00000 00 00 0 0 0000 0 0 0  000 0 1 0 0
00000 00 00 0 1 3fff 0 0 0  000 0 1 0 0

// ==== all.f ====
hazard_pkg.sv
hazard_detect.sv
hazard_fsm.sv
hazard_unit.sv
hazard_unit_tb.sv

// ==== Makefile ====
# verilator build and run for the hazard unit testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module hazard_unit_tb -f all.f -Mdir obj_dir -o hazard_unit_tb

# the simulation output is searched for the pass line, no log is kept
run: compile
	@out="$$(./obj_dir/hazard_unit_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir
